// ==== design/arp_pkg.sv ====
package arp_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Lengths in bytes.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int ETH_HDR_LEN   = 14;
  localparam int ARP_HDR_LEN   = 28;
  localparam int ARP_FRAME_LEN = 42; // Ethernet header plus ARP header.

  typedef logic [7:0]               byte_t;
  typedef logic [47:0]              mac_addr_t;
  typedef logic [31:0]              ipv4_addr_t;
  typedef logic [15:0]              ethertype_t;
  typedef logic [ARP_HDR_LEN*8-1:0] arp_hdr_t;   // First byte received sits at the top.
  typedef logic [5:0]               byte_cnt_t;  // All ones means overflow.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Protocol constants.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam ethertype_t  ETHERTYPE_ARP    = 16'h0806;
  localparam logic [15:0] ARP_OPER_REQUEST = 16'd1;
  localparam logic [15:0] ARP_OPER_REPLY   = 16'd2;

  // HTYPE Ethernet, PTYPE IPv4, HLEN 6, PLEN 4.
  localparam logic [47:0] ARP_REPLY_PREFIX = 48'h0001_0800_0604;

  // Low bit of each field within arp_hdr_t.
  localparam int ARP_OPER_OFS = 160; // Bytes 6..7.
  localparam int ARP_SHA_OFS  = 112; // Bytes 8..13.
  localparam int ARP_SPA_OFS  = 80;  // Bytes 14..17.
  localparam int ARP_TPA_OFS  = 0;   // Bytes 24..27.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // State machines.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic {
    hdr_s,
    pay_s
  } parse_state_e;

  typedef enum logic {
    idle_s,
    rx_s
  } rx_state_e;

  typedef enum logic {
    tx_idle_s,
    tx_busy_s
  } tx_state_e;

endpackage

// ==== design/arp_strm_if.sv ====
`timescale 1ns/1ps

interface arp_strm_if;

  arp_pkg::byte_t      dat;
  logic                val;       // One per payload byte, no gaps inside a frame.
  logic                err;       // Single cycle, kills the frame in flight.
  arp_pkg::ethertype_t ethertype; // Held for the whole payload.

  modport src (
    output dat,
    output val,
    output err,
    output ethertype
  );

  modport snk (
    input dat,
    input val,
    input err,
    input ethertype
  );

endinterface

// ==== design/mac_rx_parse.sv ====
`timescale 1ns/1ps

module mac_rx_parse (
  input  logic           clk,
  input  logic           fsm_rst,
  input  arp_pkg::byte_t rx_dat,
  input  logic           rx_val,
  input  logic           rx_err,
  arp_strm_if.src        strm
);

  arp_pkg::parse_state_e state;
  logic [3:0]            hdr_cnt;
  logic                  skip;     // Rest of an errored frame is ignored.
  logic                  hdr_byte;

  assign hdr_byte = rx_val && !skip && (state == arp_pkg::hdr_s);

  always_ff @(posedge clk) begin
    strm.dat <= rx_dat;
    if (hdr_byte && hdr_cnt == 4'd12) strm.ethertype[15:8] <= rx_dat;
    if (hdr_byte && hdr_cnt == 4'd13) strm.ethertype[7:0]  <= rx_dat;
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= arp_pkg::hdr_s;
      hdr_cnt  <= '0;
      skip     <= 1'b0;
      strm.val <= 1'b0;
      strm.err <= 1'b0;
    end
    else begin
      strm.err <= rx_err;
      strm.val <= rx_val && !rx_err && (state == arp_pkg::pay_s);
      if (rx_err) begin
        state   <= arp_pkg::hdr_s;
        hdr_cnt <= '0;
        skip    <= rx_val; // Hold off until the frame ends.
      end
      else if (!rx_val) begin
        state   <= arp_pkg::hdr_s;
        hdr_cnt <= '0;
        skip    <= 1'b0;
      end
      else if (hdr_byte) begin
        hdr_cnt <= hdr_cnt + 4'd1;
        if (hdr_cnt == 4'(arp_pkg::ETH_HDR_LEN - 1)) state <= arp_pkg::pay_s;
      end
    end
  end

endmodule

// ==== design/arp_rx.sv ====
`timescale 1ns/1ps

module arp_rx (
  input  logic                clk,
  input  logic                fsm_rst,
  input  arp_pkg::ipv4_addr_t dev_ipv4,
  arp_strm_if.snk             strm,
  output logic                send,
  output arp_pkg::mac_addr_t  req_mac,
  output arp_pkg::ipv4_addr_t req_ipv4
);

  localparam int HDR_W = arp_pkg::ARP_HDR_LEN * 8;

  arp_pkg::arp_hdr_t  cur_hdr;
  arp_pkg::arp_hdr_t  hdr;
  arp_pkg::byte_cnt_t byte_cnt;
  arp_pkg::rx_state_e state;
  logic               done;
  logic               is_arp;
  logic               ovf;
  logic               rx_rst;

  assign is_arp = (strm.ethertype == arp_pkg::ETHERTYPE_ARP);
  assign ovf    = (byte_cnt == '1); // Counter saturated, packet too long.
  assign rx_rst = fsm_rst || done || ovf || strm.err;

  always_ff @(posedge clk) begin
    if (strm.val) cur_hdr <= {cur_hdr[HDR_W-9:0], strm.dat};
  end

  always_ff @(posedge clk) begin
    if (byte_cnt == arp_pkg::byte_cnt_t'(arp_pkg::ARP_HDR_LEN)) hdr <= cur_hdr;
  end

  // Overflow stays out of this reset so the count holds at all ones till val drops.
  always_ff @(posedge clk) begin
    if (fsm_rst || done || strm.err) byte_cnt <= '0;
    else if (strm.val && is_arp)     byte_cnt <= ovf ? byte_cnt : byte_cnt + 6'd1;
    else                             byte_cnt <= '0;
  end

  always_ff @(posedge clk) begin
    if (rx_rst) begin
      state <= arp_pkg::idle_s;
      done  <= 1'b0;
    end
    else begin
      case (state)
        arp_pkg::idle_s: if (strm.val && is_arp) state <= arp_pkg::rx_s;
        arp_pkg::rx_s:   if (!strm.val) done <= 1'b1; // End of packet.
        default:         state <= arp_pkg::idle_s;
      endcase
    end
  end

  assign send = done &&
                (hdr[arp_pkg::ARP_OPER_OFS +: 16] == arp_pkg::ARP_OPER_REQUEST) &&
                (hdr[arp_pkg::ARP_TPA_OFS +: 32] == dev_ipv4);

  assign req_mac  = hdr[arp_pkg::ARP_SHA_OFS +: 48];
  assign req_ipv4 = hdr[arp_pkg::ARP_SPA_OFS +: 32];

endmodule

// ==== design/arp_tx.sv ====
`timescale 1ns/1ps

module arp_tx (
  input  logic                clk,
  input  logic                fsm_rst,
  input  arp_pkg::mac_addr_t  dev_mac,
  input  arp_pkg::ipv4_addr_t dev_ipv4,
  input  logic                send,
  input  arp_pkg::mac_addr_t  req_mac,
  input  arp_pkg::ipv4_addr_t req_ipv4,
  output arp_pkg::byte_t      tx_dat,
  output logic                tx_val
);

  localparam int FRAME_W = arp_pkg::ARP_FRAME_LEN * 8;

  arp_pkg::tx_state_e  state;
  logic [5:0]          idx;
  arp_pkg::mac_addr_t  dst_mac;
  arp_pkg::ipv4_addr_t dst_ipv4;
  logic [FRAME_W-1:0]  frame;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reply frame, first byte on the wire at the top.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign frame = {
    dst_mac,                   // Ethernet destination.
    dev_mac,                   // Ethernet source.
    arp_pkg::ETHERTYPE_ARP,
    arp_pkg::ARP_REPLY_PREFIX,
    arp_pkg::ARP_OPER_REPLY,
    dev_mac,                   // Sender hardware address.
    dev_ipv4,                  // Sender protocol address.
    dst_mac,                   // Target hardware address.
    dst_ipv4                   // Target protocol address.
  };

  // Requester addresses are captured once per reply.
  always_ff @(posedge clk) begin
    if (send && state == arp_pkg::tx_idle_s) begin
      dst_mac  <= req_mac;
      dst_ipv4 <= req_ipv4;
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state <= arp_pkg::tx_idle_s;
      idx   <= '0;
    end
    else begin
      case (state)
        arp_pkg::tx_idle_s: begin
          idx <= '0;
          if (send) state <= arp_pkg::tx_busy_s; // Later sends drop while busy.
        end
        arp_pkg::tx_busy_s: begin
          idx <= idx + 6'd1;
          if (idx == 6'(arp_pkg::ARP_FRAME_LEN - 1)) begin
            state <= arp_pkg::tx_idle_s;
            idx   <= '0;
          end
        end
        default: state <= arp_pkg::tx_idle_s;
      endcase
    end
  end

  assign tx_val = (state == arp_pkg::tx_busy_s);

  // Byte idx counts from the frame start.
  assign tx_dat = frame[(arp_pkg::ARP_FRAME_LEN - 1 - int'(idx)) * 8 +: 8];

endmodule

// ==== design/arp_top.sv ====
`timescale 1ns/1ps

module arp_top (
  input  logic                clk,
  input  logic                fsm_rst,
  input  arp_pkg::mac_addr_t  dev_mac,
  input  arp_pkg::ipv4_addr_t dev_ipv4,
  input  arp_pkg::byte_t      rx_dat,
  input  logic                rx_val,
  input  logic                rx_err,
  output arp_pkg::byte_t      tx_dat,
  output logic                tx_val
);

  arp_strm_if strm ();

  logic                send;
  arp_pkg::mac_addr_t  req_mac;
  arp_pkg::ipv4_addr_t req_ipv4;

  mac_rx_parse mac_rx_parse_i (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .rx_dat  (rx_dat),
    .rx_val  (rx_val),
    .rx_err  (rx_err),
    .strm    (strm.src)
  );

  arp_rx arp_rx_i (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .dev_ipv4 (dev_ipv4),
    .strm     (strm.snk),
    .send     (send),
    .req_mac  (req_mac),
    .req_ipv4 (req_ipv4)
  );

  arp_tx arp_tx_i (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .dev_mac  (dev_mac),
    .dev_ipv4 (dev_ipv4),
    .send     (send),
    .req_mac  (req_mac),
    .req_ipv4 (req_ipv4),
    .tx_dat   (tx_dat),
    .tx_val   (tx_val)
  );

endmodule

// ==== tb/arp_top_tb.sv ====
`timescale 1ns/1ps

module arp_top_tb;

  localparam int          MAX_TESTS    = 16;
  localparam int          CYC_PER_TEST = 120;
  localparam logic [47:0] DEV_MAC      = 48'h02_00_5e_10_20_30;
  localparam logic [31:0] DEV_IPV4     = 32'hc0_a8_01_0a;
  localparam logic [31:0] OTHER_IPV4   = 32'hc0_a8_01_63;

  logic        clk;
  logic        fsm_rst;
  logic [47:0] dev_mac;
  logic [31:0] dev_ipv4;
  logic [7:0]  rx_dat;
  logic        rx_val;
  logic        rx_err;
  logic [7:0]  tx_dat;
  logic        tx_val;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // One array per column of the test table.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  string       t_name   [MAX_TESTS];
  logic [15:0] t_etype  [MAX_TESTS];
  logic [15:0] t_oper   [MAX_TESTS];
  logic [31:0] t_tpa    [MAX_TESTS];
  int          t_len    [MAX_TESTS]; // ARP payload bytes.
  int          t_err_at [MAX_TESTS]; // Frame byte carrying rx_err or -1 for none.
  int          t_gap    [MAX_TESTS]; // Idle cycles after the frame.
  logic        t_reply  [MAX_TESTS];
  int          n_tests = 0;

  integer      seed;
  int          cycles = 0;
  int          errors = 0;
  int          failed_tests = 0;
  logic        last_tx_val = 1'b0;
  logic [7:0]  frame_q[$];
  logic [7:0]  exp_q[$];
  logic [7:0]  got_q[$];

  arp_top arp_top_i (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .dev_mac  (dev_mac),
    .dev_ipv4 (dev_ipv4),
    .rx_dat   (rx_dat),
    .rx_val   (rx_val),
    .rx_err   (rx_err),
    .tx_dat   (tx_dat),
    .tx_val   (tx_val)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Reply bytes are taken mid cycle.
  always @(negedge clk) begin
    last_tx_val = tx_val;
    if (tx_val) got_q.push_back(tx_dat);
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (n_tests > 0 && cycles >= n_tests * CYC_PER_TEST) begin
      $display("timeout: run did not finish within %0d cycles", cycles);
      $display("test failed");
      $finish;
    end
  end

  task automatic add_test(input string name, input logic [15:0] etype,
                          input logic [15:0] oper, input logic [31:0] tpa, input int len,
                          input int err_at, input int gap, input logic reply);
    t_name[n_tests]   = name;
    t_etype[n_tests]  = etype;
    t_oper[n_tests]   = oper;
    t_tpa[n_tests]    = tpa;
    t_len[n_tests]    = len;
    t_err_at[n_tests] = err_at;
    t_gap[n_tests]    = gap;
    t_reply[n_tests]  = reply;
    n_tests++;
  endtask

  task automatic check_value(input string what, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      $display("mismatch %s expected %h actual %h", what, exp, act);
      errors++;
    end
  endtask

  // Broadcast request with random sender addresses and a zero target MAC.
  task automatic build_frame(input int k, input logic [47:0] sha, input logic [31:0] spa);
    logic [335:0] hdr;
    hdr = {48'hffff_ffff_ffff, sha, t_etype[k], 16'h0001, 16'h0800, 8'h06, 8'h04,
           t_oper[k], sha, spa, 48'h0, t_tpa[k]};
    frame_q.delete();
    for (int i = 0; i < 42; i++) begin
      frame_q.push_back(hdr[(41 - i) * 8 +: 8]);
    end
    for (int i = 28; i < t_len[k]; i++) begin
      frame_q.push_back(8'(i)); // Padding.
    end
  endtask

  task automatic expect_reply(input logic [47:0] sha, input logic [31:0] spa);
    logic [335:0] rep;
    rep = {sha, DEV_MAC, 16'h0806, 16'h0001, 16'h0800, 8'h06, 8'h04, 16'h0002,
           DEV_MAC, DEV_IPV4, sha, spa};
    for (int i = 0; i < 42; i++) begin
      exp_q.push_back(rep[(41 - i) * 8 +: 8]);
    end
  endtask

  task automatic drive_frame(input int err_at);
    for (int i = 0; i < frame_q.size(); i++) begin
      @(posedge clk);
      rx_dat <= frame_q[i];
      rx_val <= 1'b1;
      rx_err <= (i == err_at);
    end
    @(posedge clk);
    rx_val <= 1'b0;
    rx_err <= 1'b0;
  endtask

  task automatic check_replies(input string name);
    int waited;
    waited = 0;
    while ((last_tx_val || got_q.size() < exp_q.size()) && waited < 100) begin
      @(posedge clk);
      waited++;
    end
    if (got_q.size() != exp_q.size()) begin
      $display("%s: expected %0d reply bytes, but %0d bytes came out", name, exp_q.size(),
               got_q.size());
      errors++;
    end
    else begin
      for (int i = 0; i < exp_q.size(); i++) begin
        check_value($sformatf("%s byte %0d", name, i), exp_q[i], got_q[i]);
      end
    end
    exp_q.delete();
    got_q.delete();
  endtask

  initial begin
    int          err_before;
    logic [31:0] r_hi;
    logic [31:0] r_lo;
    logic [31:0] r_ip;
    seed     = 32'h9125_dce3;
    fsm_rst  = 1'b1;
    dev_mac  = DEV_MAC;
    dev_ipv4 = DEV_IPV4;
    rx_dat   = 8'h00;
    rx_val   = 1'b0;
    rx_err   = 1'b0;

    add_test("req_basic",  16'h0806, 16'd1, DEV_IPV4,   28, -1, 8, 1'b1);
    add_test("req_padded", 16'h0806, 16'd1, DEV_IPV4,   46, -1, 8, 1'b1);
    add_test("req_other",  16'h0806, 16'd1, OTHER_IPV4, 28, -1, 8, 1'b0);
    add_test("arp_reply",  16'h0806, 16'd2, DEV_IPV4,   28, -1, 8, 1'b0);
    add_test("ipv4_frame", 16'h0800, 16'd1, DEV_IPV4,   28, -1, 8, 1'b0);
    add_test("rx_err_mid", 16'h0806, 16'd1, DEV_IPV4,   46, 50, 8, 1'b0);
    add_test("after_err",  16'h0806, 16'd1, DEV_IPV4,   28, -1, 8, 1'b1);
    add_test("too_long",   16'h0806, 16'd1, DEV_IPV4,   64, -1, 8, 1'b0);
    add_test("after_long", 16'h0806, 16'd1, DEV_IPV4,   28, -1, 8, 1'b1);
    add_test("b2b_first",  16'h0806, 16'd1, DEV_IPV4,   28, -1, 2, 1'b1);
    add_test("b2b_second", 16'h0806, 16'd1, DEV_IPV4,   28, -1, 8, 1'b1);

    repeat (2) @(posedge clk);
    fsm_rst <= 1'b0;

    for (int k = 0; k < n_tests; k++) begin
      err_before = errors;
      r_hi = $random(seed);
      r_lo = $random(seed);
      r_ip = $random(seed);
      build_frame(k, {r_hi[15:0], r_lo}, r_ip);
      if (t_reply[k]) expect_reply({r_hi[15:0], r_lo}, r_ip);
      drive_frame(t_err_at[k]);
      repeat (t_gap[k] - 1) @(posedge clk);
      if (t_gap[k] < 8) begin
        // The next entry collects the reply still in flight.
        $display("%-12s sent, reply checked with the next entry", t_name[k]);
      end
      else begin
        check_replies(t_name[k]);
        if (errors == err_before) begin
          $display("%-12s ok", t_name[k]);
        end
        else begin
          $display("%-12s FAILED with %0d errors", t_name[k], errors - err_before);
          failed_tests++;
        end
      end
    end

    $display("%0d entries run, %0d failed, %0d errors", n_tests, failed_tests, errors);
    if (errors == 0) begin
      $display("test passed");
    end
    else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== arp_top.f ====
design/arp_pkg.sv
design/arp_strm_if.sv
design/mac_rx_parse.sv
design/arp_rx.sv
design/arp_tx.sv
design/arp_top.sv
tb/arp_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ARP testbench with Verilator.
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --top-module arp_top_tb -f arp_top.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Varp_top_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" sim.log; then
  exit 1
fi
exit 0
